// ==== rtl/trace_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types and constants for the retirement trace
// subsystem. Every stage and the top level import this
// package for the packet formats passed down the pipeline
// and for the trace port record
////////////////////////////////////////////////////////////

package trace_pkg;

  // Debug entry causes as they appear in dcsr.cause and on the trace port
  localparam logic [2:0] DBG_CAUSE_EBREAK  = 3'd1;
  localparam logic [2:0] DBG_CAUSE_HALTREQ = 3'd3;
  localparam logic [2:0] DBG_CAUSE_STEP    = 3'd4;

  // Field positions inside the dcsr shadow
  localparam int unsigned STEP_BIT  = 2;
  localparam int unsigned CAUSE_LSB = 6;

  // One fetched instruction as presented by the front end
  typedef struct packed {
    logic [31:0] pc;
    logic        exc;
    logic [5:0]  exc_cause;
    logic        is_ebreak;
    logic        is_dret;
  } fetch_pkt_t;

  // Marks the first instruction of a trap or interrupt handler
  typedef struct packed {
    logic       intr;
    logic       exception;
    logic       interrupt;
    logic [5:0] cause;
  } intr_t;

  // Trap raised by the retiring instruction itself
  typedef struct packed {
    logic       exception;
    logic       debug;
    logic [5:0] exception_cause;
    logic [2:0] debug_cause;
  } trap_t;

  // Asynchronous events attached at fetch
  typedef struct packed {
    logic       irq;
    logic [4:0] irq_id;
    logic       dbg;
    logic [2:0] dbg_cause;
  } tag_t;

  // Packet carried from one stage register to the next
  typedef struct packed {
    logic       valid;
    fetch_pkt_t instr;
    tag_t       tag;
    trap_t      trap;
  } stage_pkt_t;

  // Trace port record, valid-only with no back-pressure
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    intr_t       intr;
    trap_t       trap;
    logic [2:0]  dbg;
    logic [31:0] mcause;
    logic [31:0] dcsr;
  } trace_t;

endpackage

// ==== rtl/trace_fetch_tag.sv ====
////////////////////////////////////////////////////////////
// Fetch stage of the trace pipeline. Interrupt and debug
// acknowledges are held until a valid instruction is
// fetched and are then tagged onto that instruction
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module trace_fetch_tag (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_valid_i,
  input  trace_pkg::fetch_pkt_t fetch_i,
  input  logic                  irq_ack_i,
  input  logic [4:0]            irq_id_i,
  input  logic                  dbg_ack_i,
  input  logic [2:0]            dbg_cause_i,
  output trace_pkg::stage_pkt_t pkt_o
);
  import trace_pkg::*;

  // Pending acknowledges waiting for the next valid fetch
  logic       irq_pend_q;
  logic [4:0] irq_id_q;
  logic       dbg_pend_q;
  logic [2:0] dbg_cause_q;

  tag_t       tag_d;
  stage_pkt_t pkt_d;
  stage_pkt_t pkt_q;

  ////////////////////////////////////////////////////////////
  // Tag selection
  ////////////////////////////////////////////////////////////

  // An acknowledge in this cycle takes priority over a held one
  // of the same kind, since it is the more recent event
  always_comb begin
    tag_d = '0;
    if (fetch_valid_i) begin
      if (irq_ack_i) begin
        tag_d.irq    = 1'b1;
        tag_d.irq_id = irq_id_i;
      end else if (irq_pend_q) begin
        tag_d.irq    = 1'b1;
        tag_d.irq_id = irq_id_q;
      end
      if (dbg_ack_i) begin
        tag_d.dbg       = 1'b1;
        tag_d.dbg_cause = dbg_cause_i;
      end else if (dbg_pend_q) begin
        tag_d.dbg       = 1'b1;
        tag_d.dbg_cause = dbg_cause_q;
      end
    end
  end

  // Bubbles carry a zero payload so later stages see clean fields
  always_comb begin
    pkt_d       = '0;
    pkt_d.valid = fetch_valid_i;
    pkt_d.instr = fetch_valid_i ? fetch_i : '0;
    pkt_d.tag   = tag_d;
  end

  ////////////////////////////////////////////////////////////
  // Pending registers and stage register
  ////////////////////////////////////////////////////////////

  // Any valid fetch consumes whatever was pending
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_pend_q <= 1'b0;
      dbg_pend_q <= 1'b0;
    end else begin
      irq_pend_q <= fetch_valid_i ? 1'b0 : (irq_pend_q || irq_ack_i);
      dbg_pend_q <= fetch_valid_i ? 1'b0 : (dbg_pend_q || dbg_ack_i);
    end
  end

  // A newer acknowledge overwrites an unconsumed one
  always_ff @(posedge clk_i) begin
    if (irq_ack_i && !fetch_valid_i) begin
      irq_id_q <= irq_id_i;
    end
    if (dbg_ack_i && !fetch_valid_i) begin
      dbg_cause_q <= dbg_cause_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pkt_q <= '0;
    end else begin
      pkt_q <= pkt_d;
    end
  end

  assign pkt_o = pkt_q;

endmodule

// ==== rtl/trace_trap_merge.sv ====
////////////////////////////////////////////////////////////
// Execute stage of the trace pipeline. Builds the trap word
// of each instruction from its exception, ebreak and the
// single-step request, and registers the packet onward
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module trace_trap_merge (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  trace_pkg::stage_pkt_t pkt_i,
  input  logic                  step_i,
  input  logic                  debug_mode_i,
  output trace_pkg::stage_pkt_t pkt_o
);
  import trace_pkg::*;

  trap_t      trap_d;
  stage_pkt_t pkt_d;
  stage_pkt_t pkt_q;

  ////////////////////////////////////////////////////////////
  // Trap word
  ////////////////////////////////////////////////////////////

  // Debug mode comes from the retire stage register, so it
  // reflects every instruction that has already retired
  // Instructions past this stage when the mode changes keep
  // the trap word they were given here
  always_comb begin
    trap_d = '0;
    if (pkt_i.valid && !debug_mode_i) begin
      // A synchronous exception is reported with its own cause
      if (pkt_i.instr.exc) begin
        trap_d.exception       = 1'b1;
        trap_d.exception_cause = pkt_i.instr.exc_cause;
      end

      // Single step wins over ebreak when both apply
      // dret never steps since it leaves debug mode itself
      if (step_i && !pkt_i.instr.is_dret) begin
        trap_d.debug       = 1'b1;
        trap_d.debug_cause = DBG_CAUSE_STEP;
      end else if (pkt_i.instr.is_ebreak) begin
        trap_d.debug       = 1'b1;
        trap_d.debug_cause = DBG_CAUSE_EBREAK;
      end
    end
  end

  // Everything except the trap word passes unchanged
  // For a bubble the trap word stays zero
  always_comb begin
    pkt_d      = pkt_i;
    pkt_d.trap = trap_d;
  end

  ////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pkt_q <= '0;
    end else begin
      pkt_q <= pkt_d;
    end
  end

  assign pkt_o = pkt_q;

endmodule

// ==== rtl/trace_retire.sv ====
////////////////////////////////////////////////////////////
// Retire stage of the trace pipeline. Keeps debug mode, the
// trap word of the last retired instruction and the mcause
// and dcsr shadows, and drives the registered trace record
// The trace port is valid-only and cannot be stalled
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module trace_retire (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  trace_pkg::stage_pkt_t pkt_i,
  input  logic                  step_i,
  output trace_pkg::trace_t     trace_o,
  output logic                  debug_mode_o
);
  import trace_pkg::*;

  // Trap word of the most recently retired instruction
  trap_t       last_trap_q;
  logic        debug_mode_q;
  logic        debug_mode_d;
  logic [31:0] mcause_q;
  logic [31:0] mcause_d;
  logic [31:0] dcsr_q;
  logic [31:0] dcsr_d;
  intr_t       intr_d;
  logic [2:0]  dbg_d;
  trace_t      trace_d;
  trace_t      trace_q;

  ////////////////////////////////////////////////////////////
  // Handler entry and debug entry
  ////////////////////////////////////////////////////////////

  // The instruction after a trapping one is the first of the
  // handler, and an exception there outranks an interrupt tag
  always_comb begin
    intr_d = '0;
    dbg_d  = 3'd0;
    if (pkt_i.valid) begin
      if (last_trap_q.exception) begin
        intr_d.intr      = 1'b1;
        intr_d.exception = 1'b1;
        intr_d.cause     = last_trap_q.exception_cause;
      end else if (pkt_i.tag.irq) begin
        intr_d.intr      = 1'b1;
        intr_d.interrupt = 1'b1;
        intr_d.cause     = {1'b0, pkt_i.tag.irq_id};
      end

      // Debug traps of the previous instruction outrank a halt tag
      if (last_trap_q.debug) begin
        dbg_d = last_trap_q.debug_cause;
      end else if (pkt_i.tag.dbg) begin
        dbg_d = pkt_i.tag.dbg_cause;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Debug mode and CSR shadows
  ////////////////////////////////////////////////////////////

  always_comb begin
    debug_mode_d = debug_mode_q;
    if (pkt_i.valid) begin
      // The dret itself retires in debug mode and the mode drops after it
      if (pkt_i.instr.is_dret) begin
        debug_mode_d = 1'b0;
      end
      if (dbg_d != 3'd0) begin
        debug_mode_d = 1'b1;
      end
    end

    mcause_d = mcause_q;
    if (intr_d.intr) begin
      mcause_d = {intr_d.interrupt, 25'd0, intr_d.cause};
    end

    // The step bit mirrors the request, the cause keeps the last entry
    dcsr_d           = dcsr_q;
    dcsr_d[STEP_BIT] = step_i;
    if (dbg_d != 3'd0) begin
      dcsr_d[CAUSE_LSB +: 3] = dbg_d;
    end
  end

  // The record shows the shadows with this retirement applied
  always_comb begin
    trace_d        = '0;
    trace_d.valid  = pkt_i.valid;
    trace_d.pc     = pkt_i.instr.pc;
    trace_d.intr   = intr_d;
    trace_d.trap   = pkt_i.trap;
    trace_d.dbg    = dbg_d;
    trace_d.mcause = mcause_d;
    trace_d.dcsr   = dcsr_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_trap_q  <= '0;
      debug_mode_q <= 1'b0;
      mcause_q     <= '0;
      dcsr_q       <= '0;
      trace_q      <= '0;
    end else begin
      // Bubbles leave the last trap word in place
      if (pkt_i.valid) begin
        last_trap_q <= pkt_i.trap;
      end
      debug_mode_q <= debug_mode_d;
      mcause_q     <= mcause_d;
      dcsr_q       <= dcsr_d;
      trace_q      <= trace_d;
    end
  end

  assign trace_o      = trace_q;
  assign debug_mode_o = debug_mode_q;

endmodule

// ==== rtl/trace_top.sv ====
////////////////////////////////////////////////////////////
// Top level of the retirement trace subsystem. Chains the
// fetch, execute and retire stages, three cycles from
// fetch to the trace port, with debug mode fed back from
// retire to execute
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module trace_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_valid_i,
  input  trace_pkg::fetch_pkt_t fetch_i,
  input  logic                  irq_ack_i,
  input  logic [4:0]            irq_id_i,
  input  logic                  dbg_ack_i,
  input  logic [2:0]            dbg_cause_i,
  input  logic                  step_i,
  output trace_pkg::trace_t     trace_o,
  output logic                  debug_mode_o
);
  import trace_pkg::*;

  // Packets between the stage registers
  stage_pkt_t fetch_pkt;
  stage_pkt_t merge_pkt;

  // Fetch stage tags acknowledges onto instructions
  trace_fetch_tag u_fetch_tag (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .irq_ack_i     (irq_ack_i),
    .irq_id_i      (irq_id_i),
    .dbg_ack_i     (dbg_ack_i),
    .dbg_cause_i   (dbg_cause_i),
    .pkt_o         (fetch_pkt)
  );

  // Execute stage builds the trap word
  trace_trap_merge u_trap_merge (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pkt_i        (fetch_pkt),
    .step_i       (step_i),
    .debug_mode_i (debug_mode_o),
    .pkt_o        (merge_pkt)
  );

  // Retire stage owns debug mode and drives the trace port
  trace_retire u_retire (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pkt_i        (merge_pkt),
    .step_i       (step_i),
    .trace_o      (trace_o),
    .debug_mode_o (debug_mode_o)
  );

endmodule

// ==== sim/trace_chk.sv ====
////////////////////////////////////////////////////////////
// Assertion checker for the retirement trace subsystem,
// bound into trace_top. Ties acknowledges and traps to
// the instruction that follows them
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module trace_chk (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  fetch_valid_i,
  input logic                  irq_ack_i,
  input trace_pkg::stage_pkt_t fetch_pkt_i,
  input trace_pkg::trace_t     trace_i
);
  import trace_pkg::*;

  // Failed assertions, summed into the testbench's closing count
  int unsigned fail_cnt = 0;
  logic        irq_wait_q;
  trap_t       prev_trap_q;

  // An acknowledge seen without a fetch is owed to the next fetch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_wait_q  <= 1'b0;
      prev_trap_q <= '0;
    end else begin
      irq_wait_q <= fetch_valid_i ? 1'b0 : (irq_wait_q || irq_ack_i);
      if (trace_i.valid) begin
        prev_trap_q <= trace_i.trap;
      end
    end
  end

  irq_tag_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && (irq_ack_i || irq_wait_q) |=> fetch_pkt_i.tag.irq)
    else begin fail_cnt++; $error("Interrupt acknowledge missing from the next fetch"); end

  // The handler's first instruction shows the exception cause in mcause
  exc_entry_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_i.valid && prev_trap_q.exception |->
      trace_i.intr.exception && trace_i.mcause == {26'd0, prev_trap_q.exception_cause})
    else begin fail_cnt++; $error("Exception not followed by a matching handler entry"); end

  dbg_entry_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_i.valid && prev_trap_q.debug |-> trace_i.dbg == prev_trap_q.debug_cause)
    else begin fail_cnt++; $error("Debug trap not followed by a matching debug entry"); end

  // Only single step can share an instruction with an exception
  step_exc_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_i.valid && trace_i.trap.exception && trace_i.trap.debug |->
      trace_i.trap.debug_cause == DBG_CAUSE_STEP)
    else begin fail_cnt++; $error("Exception combined with a debug trap other than step"); end

endmodule

bind trace_top trace_chk u_trace_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .fetch_valid_i (fetch_valid_i),
  .irq_ack_i     (irq_ack_i),
  .fetch_pkt_i   (fetch_pkt),
  .trace_i       (trace_o)
);

// ==== sim/tb_trace.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the retirement trace subsystem.
// A queue model follows every driven cycle through the
// three stages and checks the record it must retire as
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_trace;
  import trace_pkg::*;

  localparam int RST_CYCLES  = 10;
  // Cycles driven by the six tests together
  localparam int TEST_CYCLES = 56;
  localparam int MARGIN      = 20;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_valid_i;
  fetch_pkt_t  fetch_i;
  logic        irq_ack_i;
  logic [4:0]  irq_id_i;
  logic        dbg_ack_i;
  logic [2:0]  dbg_cause_i;
  logic        step_i;
  trace_t      trace_o;
  logic        debug_mode_o;

  // Acknowledges for the next driven cycle, and the step level
  logic        ack_irq;
  logic [4:0]  ack_id;
  logic        ack_dbg;
  logic [2:0]  ack_cause;
  logic        step_lvl;
  integer      seed = 36007;
  string       cur_test;
  int          val_errs;
  int          proto_errs;

  // Model state, the queue holds one entry per stage register
  stage_pkt_t  pipe_q[$];
  logic        m_irq_pend;
  logic [4:0]  m_irq_id;
  logic        m_dbg_pend;
  logic [2:0]  m_dbg_cause;
  logic        m_mode;
  trap_t       m_last_trap;
  logic [31:0] m_mcause;
  logic [31:0] m_dcsr;
  logic        m_prev_step;

  trace_top u_trace_top (
    .clk_i, .rst_ni, .fetch_valid_i, .fetch_i, .irq_ack_i, .irq_id_i,
    .dbg_ack_i, .dbg_cause_i, .step_i, .trace_o, .debug_mode_o
  );

  always #5 clk_i = ~clk_i;

  task automatic cmp_trap(input string what, input trap_t exp, input trap_t act);
    if (act !== exp) begin
      val_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic cmp_intr(input string what, input intr_t exp, input intr_t act);
    if (act !== exp) begin
      val_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic cmp_dbg(input string what, input logic [2:0] exp, input logic [2:0] act);
    if (act !== exp) begin
      val_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic cmp_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      val_errs++;
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Retirement model, rules 2 to 5, checked against trace_o
  ////////////////////////////////////////////////////////////

  task automatic retire_and_check(input stage_pkt_t rec);
    trace_t exp;
    exp = '0;
    if (rec.valid) begin
      exp.valid = 1'b1;
      exp.pc    = rec.instr.pc;
      exp.trap  = rec.trap;
      // A previous exception opens a handler and outranks an interrupt
      if (m_last_trap.exception) begin
        exp.intr = '{intr: 1'b1, exception: 1'b1, interrupt: 1'b0,
                     cause: m_last_trap.exception_cause};
      end else if (rec.tag.irq) begin
        exp.intr = '{intr: 1'b1, exception: 1'b0, interrupt: 1'b1,
                     cause: {1'b0, rec.tag.irq_id}};
      end
      if (m_last_trap.debug) exp.dbg = m_last_trap.debug_cause;
      else if (rec.tag.dbg) exp.dbg = rec.tag.dbg_cause;
      if (rec.instr.is_dret) m_mode = 1'b0;
      if (exp.dbg != 3'd0) begin
        m_mode = 1'b1;
        m_dcsr[CAUSE_LSB +: 3] = exp.dbg;
      end
      if (exp.intr.intr) m_mcause = {exp.intr.interrupt, 25'd0, exp.intr.cause};
      m_last_trap = rec.trap;
    end
    m_dcsr[STEP_BIT] = m_prev_step;
    if (rec.valid && trace_o.valid !== 1'b1) begin
      proto_errs++;
      $display("%s: pc %h did not retire three cycles after its fetch", cur_test, exp.pc);
    end else if (!rec.valid && trace_o.valid !== 1'b0) begin
      proto_errs++;
      $display("%s: trace port retired pc %h with no fetch behind it", cur_test, trace_o.pc);
    end else if (rec.valid) begin
      cmp_word("pc", exp.pc, trace_o.pc);
      cmp_trap("trap", exp.trap, trace_o.trap);
      cmp_intr("intr", exp.intr, trace_o.intr);
      cmp_dbg("dbg", exp.dbg, trace_o.dbg);
      cmp_word("mcause", m_mcause, trace_o.mcause);
      cmp_word("dcsr", m_dcsr, trace_o.dcsr);
    end
    cmp_word("debug_mode", {31'd0, m_mode}, {31'd0, debug_mode_o});
  endtask

  // One clock: check the retiring entry, trap the executing one, drive a fetch
  task automatic run_cycle(input logic valid, input fetch_pkt_t f);
    stage_pkt_t rec;
    @(posedge clk_i);
    #1;
    rec = pipe_q.pop_front();
    retire_and_check(rec);
    // Rule 1 sees the step level driven now and the mode after this retirement
    rec      = pipe_q[1];
    rec.trap = '0;
    if (rec.valid && !m_mode) begin
      if (rec.instr.exc) begin
        rec.trap.exception       = 1'b1;
        rec.trap.exception_cause = rec.instr.exc_cause;
      end
      if (step_lvl && !rec.instr.is_dret) begin
        rec.trap.debug       = 1'b1;
        rec.trap.debug_cause = DBG_CAUSE_STEP;
      end else if (rec.instr.is_ebreak) begin
        rec.trap.debug       = 1'b1;
        rec.trap.debug_cause = DBG_CAUSE_EBREAK;
      end
    end
    pipe_q[1] = rec;
    fetch_valid_i = valid;
    fetch_i       = valid ? f : '0;
    irq_ack_i     = ack_irq;
    irq_id_i      = ack_id;
    dbg_ack_i     = ack_dbg;
    dbg_cause_i   = ack_cause;
    step_i        = step_lvl;
    // Acknowledges attach to this fetch or wait for the next one
    rec       = '0;
    rec.valid = valid;
    rec.instr = fetch_i;
    if (valid) begin
      rec.tag.irq       = ack_irq || m_irq_pend;
      rec.tag.irq_id    = ack_irq ? ack_id : (m_irq_pend ? m_irq_id : 5'd0);
      rec.tag.dbg       = ack_dbg || m_dbg_pend;
      rec.tag.dbg_cause = ack_dbg ? ack_cause : (m_dbg_pend ? m_dbg_cause : 3'd0);
      m_irq_pend = 1'b0;
      m_dbg_pend = 1'b0;
    end else begin
      if (ack_irq) {m_irq_pend, m_irq_id} = {1'b1, ack_id};
      if (ack_dbg) {m_dbg_pend, m_dbg_cause} = {1'b1, ack_cause};
    end
    pipe_q.push_back(rec);
    m_prev_step = step_lvl;
    ack_irq     = 1'b0;
    ack_dbg     = 1'b0;
  endtask

  task automatic send_instr(input logic exc, input logic ebreak, input logic dret);
    fetch_pkt_t  f;
    logic [31:0] r;
    r           = $random(seed);
    f.pc        = {r[31:2], 2'b00};
    r           = $random(seed);
    f.exc       = exc;
    f.exc_cause = exc ? r[5:0] : 6'd0;
    f.is_ebreak = ebreak;
    f.is_dret   = dret;
    run_cycle(1'b1, f);
  endtask

  task automatic send_bubbles(input int n);
    repeat (n) run_cycle(1'b0, '0);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_plain();
    cur_test = "plain stream";
    send_instr(0, 0, 0);
    send_instr(0, 0, 0);
    send_bubbles(1);
    send_instr(0, 0, 0);
    send_bubbles(2);
    send_instr(0, 0, 0);
    send_instr(0, 0, 0);
    send_bubbles(3);
  endtask

  task automatic test_exception();
    cur_test = "exception and handler";
    send_instr(1, 0, 0);
    send_instr(0, 0, 0);
    send_bubbles(3);
  endtask

  task automatic test_irq();
    logic [31:0] r;
    cur_test = "interrupt acknowledge";
    r = $random(seed);
    {ack_irq, ack_id} = {1'b1, r[4:0]};
    send_bubbles(2);
    send_instr(0, 0, 0);
    send_bubbles(3);
    // Acknowledge in the same cycle as a fetch
    r = $random(seed);
    {ack_irq, ack_id} = {1'b1, r[4:0]};
    send_instr(0, 0, 0);
    send_bubbles(3);
  endtask

  // Step is sampled in execute, one cycle after the fetch is driven
  // The level stays up while the third fetch is driven, so the first
  // instruction retires with the dcsr step bit set and the second steps too
  task automatic test_step();
    cur_test = "single step";
    step_lvl = 1'b1;
    send_instr(1, 0, 0);
    send_instr(0, 0, 0);
    send_instr(0, 0, 0);
    step_lvl = 1'b0;
    send_bubbles(3);
  endtask

  task automatic test_debug_mode();
    cur_test = "debug mode";
    send_instr(0, 1, 0);
    send_instr(1, 0, 0);
    send_instr(0, 0, 1);
    send_bubbles(3);
    send_instr(0, 1, 0);
    send_instr(0, 0, 0);
    send_bubbles(3);
    send_instr(0, 0, 1);
    send_bubbles(3);
  endtask

  task automatic test_dbg_ack();
    cur_test = "debug acknowledge";
    {ack_dbg, ack_cause} = {1'b1, DBG_CAUSE_HALTREQ};
    send_bubbles(1);
    send_instr(0, 0, 0);
    send_bubbles(3);
    send_instr(0, 0, 1);
    send_bubbles(3);
  endtask

  initial begin
    repeat (RST_CYCLES + TEST_CYCLES + MARGIN) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("Checks failed");
    $finish;
  end

  initial begin
    {clk_i, rst_ni, fetch_valid_i, irq_ack_i, dbg_ack_i, step_i} = '0;
    {fetch_i, irq_id_i, dbg_cause_i} = '0;
    {ack_irq, ack_id, ack_dbg, ack_cause, step_lvl} = '0;
    {m_irq_pend, m_irq_id, m_dbg_pend, m_dbg_cause, m_mode, m_prev_step} = '0;
    {m_last_trap, m_mcause, m_dcsr} = '0;
    val_errs   = 0;
    proto_errs = 0;
    cur_test   = "reset";
    repeat (3) pipe_q.push_back('0);
    repeat (RST_CYCLES) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_plain();
    test_exception();
    test_irq();
    test_step();
    test_debug_mode();
    test_dbg_ack();
    $display("Error count: %0d value, %0d protocol, %0d assertion", val_errs, proto_errs,
             u_trace_top.u_trace_chk.fail_cnt);
    if (val_errs + proto_errs + int'(u_trace_top.u_trace_chk.fail_cnt) == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
rtl/trace_pkg.sv
rtl/trace_fetch_tag.sv
rtl/trace_trap_merge.sv
rtl/trace_retire.sv
rtl/trace_top.sv
sim/trace_chk.sv
sim/tb_trace.sv

// ==== Makefile ====
# Verilator build and run for the retirement trace testbench
VERILATOR ?= verilator
TOP       ?= tb_trace
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
